/* exu_params.svh */
// widths and counts for the execute cluster: data path, lane count, tag
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// data path width
`define EXU_XLEN 64

// number of lanes, also the cycles each lane holds an instruction
`define EXU_LANES 4

// instruction tag width
`define EXU_TAG_W 4

`endif

/* exu_pkg.sv */
// execute cluster package: ALU op, branch and load enums, control encodings, decoded control
package exu_pkg;

  // ALU operations, encodings as in the single-issue EXU
  typedef enum logic [4:0] {
    ALU_ADD  = 5'b00000,
    ALU_SUB  = 5'b00001,
    ALU_SLT  = 5'b00010,
    ALU_SLTU = 5'b00011,
    ALU_XOR  = 5'b00100,
    ALU_AND  = 5'b00101,
    ALU_OR   = 5'b00110,
    ALU_SLL  = 5'b00111,
    ALU_SRL  = 5'b01000,
    ALU_SRA  = 5'b01001,
    ALU_MUL  = 5'b01010,
    ALU_COPY = 5'b01111
  } alu_op_e;

  // blt/bge class uses the less flag picked by the ALU op (slt or sltu)
  typedef enum logic [2:0] {
    BR_NONE = 3'b000,
    BR_JAL  = 3'b001,
    BR_JALR = 3'b010,
    BR_EQ   = 3'b100,
    BR_NE   = 3'b101,
    BR_LT   = 3'b110,
    BR_GE   = 3'b111
  } branch_e;

  typedef enum logic [2:0] {
    MEM_LB  = 3'b000,
    MEM_LBU = 3'b001,
    MEM_LH  = 3'b010,
    MEM_LHU = 3'b011,
    MEM_LW  = 3'b100,
    MEM_LWU = 3'b101,
    MEM_LD  = 3'b110
  } mem_op_e;

  // operand B sources
  localparam logic [1:0] SRC_B_RS2  = 2'b00;
  localparam logic [1:0] SRC_B_IMM  = 2'b01;
  localparam logic [1:0] SRC_B_FOUR = 2'b10;

  // ex_ctl codes
  localparam logic [3:0] EX_CSR_WRITE = 4'b0000;
  localparam logic [3:0] EX_EBREAK    = 4'b1110;

  typedef struct packed {
    logic       alu_a_pc;
    logic [1:0] alu_b_src;
    alu_op_e    alu_op;
    logic       word_cut;
    branch_e    branch;
    mem_op_e    mem_op;
    logic       mem_to_reg;
    logic [3:0] ex_ctl;
    logic       sel_csr;
    logic       invalid;
  } exu_ctl_t;

endpackage

/* exu_if.sv */
// lane issue and lane result interfaces with their modports
`include "exu_params.svh"

interface exu_issue_if import exu_pkg::*; ();

  logic                  valid;
  logic [`EXU_TAG_W-1:0] tag;
  exu_ctl_t              ctl;
  logic [`EXU_XLEN-1:0]  rs1;
  logic [`EXU_XLEN-1:0]  rs2;
  logic [`EXU_XLEN-1:0]  imm;
  logic [`EXU_XLEN-1:0]  pc;
  // load data returned for this instruction
  logic [`EXU_XLEN-1:0]  rdata;

  modport src (output valid, tag, ctl, rs1, rs2, imm, pc, rdata);
  modport dst (input valid, tag, ctl, rs1, rs2, imm, pc, rdata);

endinterface

interface exu_result_if ();

  logic                  valid;
  logic [`EXU_TAG_W-1:0] tag;
  logic [`EXU_XLEN-1:0]  gpr_wdata;
  logic [`EXU_XLEN-1:0]  next_pc;
  logic [`EXU_XLEN-1:0]  csr_wdata;
  // ebreak seen
  logic                  halt;
  logic                  illegal;

  modport src (output valid, tag, gpr_wdata, next_pc, csr_wdata, halt, illegal);
  modport dst (input valid, tag, gpr_wdata, next_pc, csr_wdata, halt, illegal);

endinterface

/* exu_dispatch.sv */
// round-robin dispatcher from the input stream to the lane issue interfaces
`include "exu_params.svh"

module exu_dispatch import exu_pkg::*; (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_valid,
  input  logic [`EXU_TAG_W-1:0] i_tag,
  input  exu_ctl_t              i_ctl,
  input  logic [`EXU_XLEN-1:0]  i_rs1,
  input  logic [`EXU_XLEN-1:0]  i_rs2,
  input  logic [`EXU_XLEN-1:0]  i_imm,
  input  logic [`EXU_XLEN-1:0]  i_pc,
  input  logic [`EXU_XLEN-1:0]  i_rdata,
  exu_issue_if.src              iss [`EXU_LANES]
);

  localparam int LANE_W = $clog2(`EXU_LANES);

  logic [LANE_W-1:0] ptr;

  // next lane to receive an instruction
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ptr <= '0;
    end else if (i_valid) begin
      ptr <= (ptr == LANE_W'(`EXU_LANES - 1)) ? '0 : ptr + 1'b1;
    end
  end

  for (genvar g = 0; g < `EXU_LANES; g++) begin : g_lane
    logic pick;
    assign pick = i_valid && (ptr == LANE_W'(g));

    always_ff @(posedge i_clk) begin
      if (i_rst) begin
        iss[g].valid <= 1'b0;
      end else begin
        iss[g].valid <= pick;
      end
    end

    always_ff @(posedge i_clk) begin
      if (pick) begin
        iss[g].tag   <= i_tag;
        iss[g].ctl   <= i_ctl;
        iss[g].rs1   <= i_rs1;
        iss[g].rs2   <= i_rs2;
        iss[g].imm   <= i_imm;
        iss[g].pc    <= i_pc;
        iss[g].rdata <= i_rdata;
      end
    end
  end

endmodule

/* exu_lane.sv */
// execute lane: operand select, ALU, branch unit, load extension, writeback select
`include "exu_params.svh"

module exu_lane import exu_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  exu_issue_if.dst  iss,
  exu_result_if.src res
);

  localparam int XW    = `EXU_XLEN;
  localparam int SH_W  = $clog2(XW);
  localparam int CNT_W = $clog2(`EXU_LANES + 1);

  logic                  busy;
  logic [CNT_W-1:0]      cnt;
  logic                  fire;
  logic [`EXU_TAG_W-1:0] tag_q;
  exu_ctl_t              ctl_q;
  logic [XW-1:0]         rs1_q;
  logic [XW-1:0]         rs2_q;
  logic [XW-1:0]         imm_q;
  logic [XW-1:0]         pc_q;
  logic [XW-1:0]         rdata_q;

  logic [XW-1:0]   src1;
  logic [XW-1:0]   src2;
  logic [XW-1:0]   imm_c;
  logic [XW-1:0]   src_a;
  logic [XW-1:0]   src_b;
  logic [XW-1:0]   diff;
  logic            borrow;
  logic            zero;
  logic            lt_s;
  logic            less;
  logic [SH_W-1:0] shamt;
  logic [XW-1:0]   sra_src;
  logic [XW-1:0]   alu_raw;
  logic [XW-1:0]   alu_res;
  logic            taken;
  logic [XW-1:0]   next_pc;
  logic [XW-1:0]   load_ext;
  logic [XW-1:0]   gpr_wdata;
  logic [XW-1:0]   csr_wdata;

  assign fire = busy && (cnt == '0);

  // hold counter, a new issue lands on the same edge as the previous result
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy      <= 1'b0;
      cnt       <= '0;
      res.valid <= 1'b0;
    end else begin
      res.valid <= fire;
      if (iss.valid) begin
        busy <= 1'b1;
        cnt  <= CNT_W'(`EXU_LANES - 1);
      end else if (fire) begin
        busy <= 1'b0;
      end else if (busy) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (iss.valid) begin
      tag_q   <= iss.tag;
      ctl_q   <= iss.ctl;
      rs1_q   <= iss.rs1;
      rs2_q   <= iss.rs2;
      imm_q   <= iss.imm;
      pc_q    <= iss.pc;
      rdata_q <= iss.rdata;
    end
  end

  // word ops see zero-extended low halves
  assign src1  = ctl_q.word_cut ? {{(XW-32){1'b0}}, rs1_q[31:0]} : rs1_q;
  assign src2  = ctl_q.word_cut ? {{(XW-32){1'b0}}, rs2_q[31:0]} : rs2_q;
  assign imm_c = ctl_q.word_cut ? {{(XW-32){1'b0}}, imm_q[31:0]} : imm_q;
  assign src_a = ctl_q.alu_a_pc ? pc_q : src1;

  always_comb begin
    case (ctl_q.alu_b_src)
      SRC_B_RS2:  src_b = src2;
      SRC_B_IMM:  src_b = imm_c;
      SRC_B_FOUR: src_b = XW'(4);
      default:    src_b = '0;
    endcase
  end

  // flags from the shared subtractor
  assign {borrow, diff} = {1'b0, src_a} - {1'b0, src_b};
  assign zero = (diff == '0);
  assign lt_s = (src_a[XW-1] != src_b[XW-1]) ? src_a[XW-1] : diff[XW-1];

  assign shamt   = ctl_q.word_cut ? SH_W'(src_b[4:0]) : src_b[SH_W-1:0];
  assign sra_src = ctl_q.word_cut ? {{(XW-32){src_a[31]}}, src_a[31:0]} : src_a;

  always_comb begin
    case (ctl_q.alu_op)
      ALU_ADD:  alu_raw = src_a + src_b;
      ALU_SUB:  alu_raw = diff;
      ALU_SLT:  alu_raw = XW'(lt_s);
      ALU_SLTU: alu_raw = XW'(borrow);
      ALU_XOR:  alu_raw = src_a ^ src_b;
      ALU_AND:  alu_raw = src_a & src_b;
      ALU_OR:   alu_raw = src_a | src_b;
      ALU_SLL:  alu_raw = src_a << shamt;
      ALU_SRL:  alu_raw = src_a >> shamt;
      ALU_SRA:  alu_raw = $signed(sra_src) >>> shamt;
      ALU_MUL:  alu_raw = src_a * src_b;
      ALU_COPY: alu_raw = imm_q;
      default:  alu_raw = '0;
    endcase
  end

  assign alu_res = ctl_q.word_cut ? {{(XW-32){alu_raw[31]}}, alu_raw[31:0]} : alu_raw;

  // less follows whichever compare the decoder chose
  always_comb begin
    case (ctl_q.alu_op)
      ALU_SLT:  less = lt_s;
      ALU_SLTU: less = borrow;
      default:  less = 1'b0;
    endcase
  end

  always_comb begin
    case (ctl_q.branch)
      BR_NONE: taken = 1'b0;
      BR_JAL:  taken = 1'b1;
      BR_JALR: taken = 1'b1;
      BR_EQ:   taken = zero;
      BR_NE:   taken = ~zero;
      BR_LT:   taken = less;
      BR_GE:   taken = ~less;
      default: taken = 1'b0;
    endcase
  end

  assign next_pc = ((ctl_q.branch == BR_JALR) ? rs1_q : pc_q) + (taken ? imm_q : XW'(4));

  always_comb begin
    case (ctl_q.mem_op)
      MEM_LB:  load_ext = {{(XW-8){rdata_q[7]}}, rdata_q[7:0]};
      MEM_LBU: load_ext = {{(XW-8){1'b0}}, rdata_q[7:0]};
      MEM_LH:  load_ext = {{(XW-16){rdata_q[15]}}, rdata_q[15:0]};
      MEM_LHU: load_ext = {{(XW-16){1'b0}}, rdata_q[15:0]};
      MEM_LW:  load_ext = {{(XW-32){rdata_q[31]}}, rdata_q[31:0]};
      MEM_LWU: load_ext = {{(XW-32){1'b0}}, rdata_q[31:0]};
      MEM_LD:  load_ext = rdata_q;
      default: load_ext = '0;
    endcase
  end

  assign gpr_wdata = ctl_q.mem_to_reg ? load_ext : (ctl_q.sel_csr ? rs2_q : alu_res);
  assign csr_wdata = (ctl_q.ex_ctl == EX_CSR_WRITE) ? src_a : '0;

  always_ff @(posedge i_clk) begin
    if (fire) begin
      res.tag       <= tag_q;
      res.gpr_wdata <= gpr_wdata;
      res.next_pc   <= next_pc;
      res.csr_wdata <= csr_wdata;
      res.halt      <= (ctl_q.ex_ctl == EX_EBREAK);
      res.illegal   <= ctl_q.invalid;
    end
  end

endmodule

/* exu_collect.sv */
// result collector: lane merge into the output stream, sticky halted flag
`include "exu_params.svh"

module exu_collect (
  exu_result_if.dst             res [`EXU_LANES],
  input  logic                  i_clk,
  input  logic                  i_rst,
  output logic                  o_valid,
  output logic [`EXU_TAG_W-1:0] o_tag,
  output logic [`EXU_XLEN-1:0]  o_gpr_wdata,
  output logic [`EXU_XLEN-1:0]  o_next_pc,
  output logic [`EXU_XLEN-1:0]  o_csr_wdata,
  output logic                  o_illegal,
  output logic                  o_halted
);

  logic [`EXU_LANES-1:0] lane_vld;
  logic [`EXU_LANES-1:0] lane_halt;
  logic [`EXU_LANES-1:0] lane_ill;
  logic [`EXU_TAG_W-1:0] lane_tag [`EXU_LANES];
  logic [`EXU_XLEN-1:0]  lane_gpr [`EXU_LANES];
  logic [`EXU_XLEN-1:0]  lane_npc [`EXU_LANES];
  logic [`EXU_XLEN-1:0]  lane_csr [`EXU_LANES];

  logic                  any_vld;
  logic                  sel_halt;
  logic                  sel_ill;
  logic [`EXU_TAG_W-1:0] sel_tag;
  logic [`EXU_XLEN-1:0]  sel_gpr;
  logic [`EXU_XLEN-1:0]  sel_npc;
  logic [`EXU_XLEN-1:0]  sel_csr;

  for (genvar g = 0; g < `EXU_LANES; g++) begin : g_unpack
    assign lane_vld[g]  = res[g].valid;
    assign lane_halt[g] = res[g].halt;
    assign lane_ill[g]  = res[g].illegal;
    assign lane_tag[g]  = res[g].tag;
    assign lane_gpr[g]  = res[g].gpr_wdata;
    assign lane_npc[g]  = res[g].next_pc;
    assign lane_csr[g]  = res[g].csr_wdata;
  end

  assign any_vld = |lane_vld;

  // round robin keeps lane pulses one-hot
  always_comb begin
    sel_halt = 1'b0;
    sel_ill  = 1'b0;
    sel_tag  = '0;
    sel_gpr  = '0;
    sel_npc  = '0;
    sel_csr  = '0;
    for (int i = 0; i < `EXU_LANES; i++) begin
      if (lane_vld[i]) begin
        sel_halt = lane_halt[i];
        sel_ill  = lane_ill[i];
        sel_tag  = lane_tag[i];
        sel_gpr  = lane_gpr[i];
        sel_npc  = lane_npc[i];
        sel_csr  = lane_csr[i];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid   <= 1'b0;
      o_illegal <= 1'b0;
      o_halted  <= 1'b0;
    end else begin
      o_valid <= any_vld;
      if (any_vld) begin
        o_illegal <= sel_ill;
        // stays set until reset
        o_halted  <= o_halted | sel_halt;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (any_vld) begin
      o_tag       <= sel_tag;
      o_gpr_wdata <= sel_gpr;
      o_next_pc   <= sel_npc;
      o_csr_wdata <= sel_csr;
    end
  end

endmodule

/* exu_cluster.sv */
// four-lane execute cluster top: control packing, dispatcher, lanes, collector
`include "exu_params.svh"

module exu_cluster import exu_pkg::*; (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_valid,
  input  logic [`EXU_TAG_W-1:0] i_tag,
  input  logic                  i_alu_a_pc,
  input  logic [1:0]            i_alu_b_src,
  input  logic [4:0]            i_alu_op,
  input  logic                  i_word_cut,
  input  logic [2:0]            i_branch,
  input  logic [2:0]            i_mem_op,
  input  logic                  i_mem_to_reg,
  input  logic [3:0]            i_ex_ctl,
  input  logic                  i_sel_csr,
  input  logic                  i_invalid,
  input  logic [`EXU_XLEN-1:0]  i_rs1,
  input  logic [`EXU_XLEN-1:0]  i_rs2,
  input  logic [`EXU_XLEN-1:0]  i_imm,
  input  logic [`EXU_XLEN-1:0]  i_pc,
  input  logic [`EXU_XLEN-1:0]  i_rdata,
  output logic                  o_valid,
  output logic [`EXU_TAG_W-1:0] o_tag,
  output logic [`EXU_XLEN-1:0]  o_gpr_wdata,
  output logic [`EXU_XLEN-1:0]  o_next_pc,
  output logic [`EXU_XLEN-1:0]  o_csr_wdata,
  output logic                  o_illegal,
  output logic                  o_halted
);

  exu_ctl_t ctl;

  assign ctl.alu_a_pc   = i_alu_a_pc;
  assign ctl.alu_b_src  = i_alu_b_src;
  assign ctl.alu_op     = alu_op_e'(i_alu_op);
  assign ctl.word_cut   = i_word_cut;
  assign ctl.branch     = branch_e'(i_branch);
  assign ctl.mem_op     = mem_op_e'(i_mem_op);
  assign ctl.mem_to_reg = i_mem_to_reg;
  assign ctl.ex_ctl     = i_ex_ctl;
  assign ctl.sel_csr    = i_sel_csr;
  assign ctl.invalid    = i_invalid;

  exu_issue_if  iss_if [`EXU_LANES] ();
  exu_result_if res_if [`EXU_LANES] ();

  exu_dispatch u_dispatch (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (i_valid),
    .i_tag   (i_tag),
    .i_ctl   (ctl),
    .i_rs1   (i_rs1),
    .i_rs2   (i_rs2),
    .i_imm   (i_imm),
    .i_pc    (i_pc),
    .i_rdata (i_rdata),
    .iss     (iss_if)
  );

  for (genvar g = 0; g < `EXU_LANES; g++) begin : g_lane
    exu_lane u_lane (
      .i_clk (i_clk),
      .i_rst (i_rst),
      .iss   (iss_if[g]),
      .res   (res_if[g])
    );
  end

  exu_collect u_collect (
    .res         (res_if),
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .o_valid     (o_valid),
    .o_tag       (o_tag),
    .o_gpr_wdata (o_gpr_wdata),
    .o_next_pc   (o_next_pc),
    .o_csr_wdata (o_csr_wdata),
    .o_illegal   (o_illegal),
    .o_halted    (o_halted)
  );

endmodule

/* exu_checker.sv */
// testbench monitor: queues expected results at issue and compares the DUT output stream
`include "exu_params.svh"

module exu_checker (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_issue,
  input  logic [`EXU_TAG_W-1:0] i_issue_tag,
  input  logic [`EXU_XLEN-1:0]  i_exp_gpr,
  input  logic [`EXU_XLEN-1:0]  i_exp_npc,
  input  logic [`EXU_XLEN-1:0]  i_exp_csr,
  input  logic                  i_exp_ill,
  input  logic                  i_exp_halt,
  input  logic                  i_valid,
  input  logic [`EXU_TAG_W-1:0] i_tag,
  input  logic [`EXU_XLEN-1:0]  i_gpr_wdata,
  input  logic [`EXU_XLEN-1:0]  i_next_pc,
  input  logic [`EXU_XLEN-1:0]  i_csr_wdata,
  input  logic                  i_illegal,
  input  logic                  i_halted,
  output int                    o_pass,
  output int                    o_fail,
  output int                    o_done,
  output int                    o_pending
);

  typedef struct packed {
    logic [`EXU_TAG_W-1:0] tag;
    logic [`EXU_XLEN-1:0]  gpr;
    logic [`EXU_XLEN-1:0]  npc;
    logic [`EXU_XLEN-1:0]  csr;
    logic                  ill;
    logic                  halt;
    logic [31:0]           cyc;
  } exp_t;

  exp_t        q [$];
  logic [31:0] cyc;
  logic        halted_exp;

  initial begin
    o_pass = 0;
    o_fail = 0;
    o_done = 0;
    o_pending = 0;
    cyc = '0;
    halted_exp = 1'b0;
  end

  task automatic compare(input string name, input logic [63:0] got,
                         input logic [63:0] want, inout logic ok);
    if (got !== want) begin
      $display("mismatch %s got %h expected %h", name, got, want);
      ok = 1'b0;
    end
  endtask

  always @(posedge i_clk) begin
    exp_t e;
    logic ok;
    if (i_rst) begin
      q.delete();
      halted_exp = 1'b0;
    end else begin
      if (i_valid) begin
        if (q.size() == 0) begin
          $display("result with tag %h arrived with nothing expected", i_tag);
          o_fail++;
        end else begin
          e = q.pop_front();
          ok = 1'b1;
          halted_exp = halted_exp | e.halt;
          compare("o_tag", 64'(i_tag), 64'(e.tag), ok);
          compare("o_gpr_wdata", i_gpr_wdata, e.gpr, ok);
          compare("o_next_pc", i_next_pc, e.npc, ok);
          compare("o_csr_wdata", i_csr_wdata, e.csr, ok);
          compare("o_illegal", 64'(i_illegal), 64'(e.ill), ok);
          compare("o_halted", 64'(i_halted), 64'(halted_exp), ok);
          // visible after issue edge + 6, sampled one edge later
          if (cyc - e.cyc != 32'(`EXU_LANES + 3)) begin
            $display("result for tag %h came %0d cycles after issue instead of %0d",
                     e.tag, cyc - e.cyc, `EXU_LANES + 3);
            ok = 1'b0;
          end
          $display("test %0d tag %h %s", o_done, e.tag, ok ? "ok" : "failed");
          if (ok) begin
            o_pass++;
          end else begin
            o_fail++;
          end
          o_done++;
        end
      end
      if (i_issue) begin
        q.push_back({i_issue_tag, i_exp_gpr, i_exp_npc, i_exp_csr, i_exp_ill, i_exp_halt, cyc});
      end
    end
    cyc = cyc + 1;
    o_pending = q.size();
  end

endmodule

/* exu_cluster_tb.sv */
// testbench top with clock, reset, vector file, stimulus, timeout and summary
`include "exu_params.svh"

module exu_cluster_tb;

  localparam int MAX_VEC  = 64;
  localparam int MAX_GAP  = 2;
  // leading vectors go out back to back across all lanes
  localparam int BURST    = 8;

  logic                  i_clk;
  logic                  i_rst;
  logic                  i_valid;
  logic [`EXU_TAG_W-1:0] i_tag;
  logic                  i_alu_a_pc;
  logic [1:0]            i_alu_b_src;
  logic [4:0]            i_alu_op;
  logic                  i_word_cut;
  logic [2:0]            i_branch;
  logic [2:0]            i_mem_op;
  logic                  i_mem_to_reg;
  logic [3:0]            i_ex_ctl;
  logic                  i_sel_csr;
  logic                  i_invalid;
  logic [`EXU_XLEN-1:0]  i_rs1;
  logic [`EXU_XLEN-1:0]  i_rs2;
  logic [`EXU_XLEN-1:0]  i_imm;
  logic [`EXU_XLEN-1:0]  i_pc;
  logic [`EXU_XLEN-1:0]  i_rdata;
  logic                  o_valid;
  logic [`EXU_TAG_W-1:0] o_tag;
  logic [`EXU_XLEN-1:0]  o_gpr_wdata;
  logic [`EXU_XLEN-1:0]  o_next_pc;
  logic [`EXU_XLEN-1:0]  o_csr_wdata;
  logic                  o_illegal;
  logic                  o_halted;

  // expected values handed to the checker with each issue
  logic [`EXU_XLEN-1:0]  exp_gpr;
  logic [`EXU_XLEN-1:0]  exp_npc;
  logic [`EXU_XLEN-1:0]  exp_csr;
  logic                  exp_ill;
  logic                  exp_halt;

  int pass_cnt;
  int fail_cnt;
  int done_cnt;
  int pending;

  logic [63:0] vec [MAX_VEC][20];
  int          n_vec;
  int          cycles;
  int          limit;

  exu_cluster i_dut (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_valid      (i_valid),
    .i_tag        (i_tag),
    .i_alu_a_pc   (i_alu_a_pc),
    .i_alu_b_src  (i_alu_b_src),
    .i_alu_op     (i_alu_op),
    .i_word_cut   (i_word_cut),
    .i_branch     (i_branch),
    .i_mem_op     (i_mem_op),
    .i_mem_to_reg (i_mem_to_reg),
    .i_ex_ctl     (i_ex_ctl),
    .i_sel_csr    (i_sel_csr),
    .i_invalid    (i_invalid),
    .i_rs1        (i_rs1),
    .i_rs2        (i_rs2),
    .i_imm        (i_imm),
    .i_pc         (i_pc),
    .i_rdata      (i_rdata),
    .o_valid      (o_valid),
    .o_tag        (o_tag),
    .o_gpr_wdata  (o_gpr_wdata),
    .o_next_pc    (o_next_pc),
    .o_csr_wdata  (o_csr_wdata),
    .o_illegal    (o_illegal),
    .o_halted     (o_halted)
  );

  exu_checker u_chk (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_issue     (i_valid),
    .i_issue_tag (i_tag),
    .i_exp_gpr   (exp_gpr),
    .i_exp_npc   (exp_npc),
    .i_exp_csr   (exp_csr),
    .i_exp_ill   (exp_ill),
    .i_exp_halt  (exp_halt),
    .i_valid     (o_valid),
    .i_tag       (o_tag),
    .i_gpr_wdata (o_gpr_wdata),
    .i_next_pc   (o_next_pc),
    .i_csr_wdata (o_csr_wdata),
    .i_illegal   (o_illegal),
    .i_halted    (o_halted),
    .o_pass      (pass_cnt),
    .o_fail      (fail_cnt),
    .o_done      (done_cnt),
    .o_pending   (pending)
  );

  initial i_clk = 1'b0;
  always #4 i_clk = ~i_clk;

  // watchdog with a limit set once the vectors are known
  always @(posedge i_clk) begin
    if (!i_rst) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles > limit) begin
        $display("timeout after %0d cycles with %0d of %0d results seen",
                 cycles, done_cnt, n_vec);
        $display("Result: FAILED");
        $finish;
      end
    end
  end

  task automatic load_vectors();
    int    fd;
    int    code;
    string line;
    logic [63:0] f [20];
    n_vec = 0;
    fd = $fopen("exu_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open the test data file exu_testdata.txt");
    end else begin
      while (!$feof(fd) && n_vec < MAX_VEC) begin
        code = $fgets(line, fd);
        // skip comments and blank lines
        if (code > 1 && line[0] != 8'h23) begin
          code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                         f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]);
          if (code == 20) begin
            for (int k = 0; k < 20; k++) begin
              vec[n_vec][k] = f[k];
            end
            n_vec++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_vector(input int idx);
    i_valid      <= 1'b1;
    i_tag        <= `EXU_TAG_W'(idx % 16);
    i_alu_a_pc   <= vec[idx][0][0];
    i_alu_b_src  <= vec[idx][1][1:0];
    i_alu_op     <= vec[idx][2][4:0];
    i_word_cut   <= vec[idx][3][0];
    i_branch     <= vec[idx][4][2:0];
    i_mem_op     <= vec[idx][5][2:0];
    i_mem_to_reg <= vec[idx][6][0];
    i_ex_ctl     <= vec[idx][7][3:0];
    i_sel_csr    <= vec[idx][8][0];
    i_invalid    <= vec[idx][9][0];
    i_rs1        <= vec[idx][10];
    i_rs2        <= vec[idx][11];
    i_imm        <= vec[idx][12];
    i_pc         <= vec[idx][13];
    i_rdata      <= vec[idx][14];
    exp_gpr      <= vec[idx][15];
    exp_npc      <= vec[idx][16];
    exp_csr      <= vec[idx][17];
    exp_ill      <= vec[idx][18][0];
    exp_halt     <= vec[idx][19][0];
  endtask

  initial begin
    int gap;
    void'($urandom(32'h441c_d6a0));
    i_rst = 1'b1;
    i_valid = 1'b0;
    i_tag = '0;
    i_alu_a_pc = 1'b0;
    i_alu_b_src = '0;
    i_alu_op = '0;
    i_word_cut = 1'b0;
    i_branch = '0;
    i_mem_op = '0;
    i_mem_to_reg = 1'b0;
    i_ex_ctl = '0;
    i_sel_csr = 1'b0;
    i_invalid = 1'b0;
    i_rs1 = '0;
    i_rs2 = '0;
    i_imm = '0;
    i_pc = '0;
    i_rdata = '0;
    exp_gpr = '0;
    exp_npc = '0;
    exp_csr = '0;
    exp_ill = 1'b0;
    exp_halt = 1'b0;
    cycles = 0;
    limit = 0;
    load_vectors();
    limit = n_vec * (MAX_GAP + 1) + `EXU_LANES + 20;
    repeat (3) @(posedge i_clk);
    i_rst <= 1'b0;
    for (int i = 0; i < n_vec; i++) begin
      @(posedge i_clk);
      drive_vector(i);
      gap = (i < BURST) ? 0 : int'($urandom % (MAX_GAP + 1));
      for (int g = 0; g < gap; g++) begin
        @(posedge i_clk);
        i_valid <= 1'b0;
      end
    end
    @(posedge i_clk);
    i_valid <= 1'b0;
    while (done_cnt < n_vec) begin
      @(posedge i_clk);
    end
    // catch any stray result
    repeat (4) @(posedge i_clk);
    if (n_vec == 0) begin
      $display("no test vectors were loaded");
    end
    if (pending != 0) begin
      $display("%0d expected results never arrived", pending);
    end
    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pending == 0 && n_vec > 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* exu_testdata.txt */
# a_pc b_src alu_op wcut branch mem_op m2r ex_ctl sel_csr invalid rs1 rs2 imm pc rdata
# then expected: gpr_wdata next_pc csr_wdata illegal halt (all hex)
0 0 00 0 0 0 0 1 0 0 5 7 0 80000000 0 c 80000004 0 0 0
0 0 01 1 0 0 0 1 0 0 1 2 0 80000000 0 ffffffffffffffff 80000004 0 0 0
0 0 00 1 0 0 0 1 0 0 7fffffff 1 0 80000000 0 ffffffff80000000 80000004 0 0 0
0 1 04 0 0 0 0 1 0 0 ff00 0 0f0f 80000000 0 f00f 80000004 0 0 0
0 0 05 0 0 0 0 1 0 0 f0f0 ff00 0 80000000 0 f000 80000004 0 0 0
0 0 06 0 0 0 0 1 0 0 f0 0f 0 80000000 0 ff 80000004 0 0 0
0 0 07 0 0 0 0 1 0 0 1 3f 0 80000000 0 8000000000000000 80000004 0 0 0
0 0 08 1 0 0 0 1 0 0 ffffffff80000000 4 0 80000000 0 8000000 80000004 0 0 0
0 0 09 1 0 0 0 1 0 0 80000000 4 0 80000000 0 fffffffff8000000 80000004 0 0 0
0 0 0a 0 0 0 0 1 0 0 ffffffffffffffff 3 0 80000000 0 fffffffffffffffd 80000004 0 0 0
0 1 0f 0 0 0 0 1 0 0 0 0 12345000 80000000 0 12345000 80000004 0 0 0
0 0 02 0 6 0 0 1 0 0 8000000000000000 1 10 80000000 0 1 80000010 0 0 0
0 0 03 0 7 0 0 1 0 0 1 ffffffffffffffff 10 80000000 0 1 80000004 0 0 0
0 0 01 0 4 0 0 1 0 0 5 5 fffffffffffffff0 80000000 0 0 7ffffff0 0 0 0
0 0 01 0 5 0 0 1 0 0 5 6 20 80000000 0 ffffffffffffffff 80000020 0 0 0
1 2 00 0 1 0 0 1 0 0 0 0 100 80000000 0 80000004 80000100 0 0 0
1 2 00 0 2 0 0 1 0 0 1000 0 8 80000000 0 80000004 1008 0 0 0
0 0 00 0 0 0 1 1 0 0 0 0 0 80000000 8899aabbccddeeff ffffffffffffffff 80000004 0 0 0
0 0 00 0 0 1 1 1 0 0 0 0 0 80000000 8899aabbccddeeff ff 80000004 0 0 0
0 0 00 0 0 2 1 1 0 0 0 0 0 80000000 8899aabbccddeeff ffffffffffffeeff 80000004 0 0 0
0 0 00 0 0 3 1 1 0 0 0 0 0 80000000 8899aabbccddeeff eeff 80000004 0 0 0
0 0 00 0 0 4 1 1 0 0 0 0 0 80000000 8899aabbccddeeff ffffffffccddeeff 80000004 0 0 0
0 0 00 0 0 5 1 1 0 0 0 0 0 80000000 8899aabbccddeeff ccddeeff 80000004 0 0 0
0 0 00 0 0 6 1 1 0 0 0 0 0 80000000 8899aabbccddeeff 8899aabbccddeeff 80000004 0 0 0
0 0 00 0 0 0 0 0 1 0 abc 123 0 80000000 0 123 80000004 abc 0 0
0 0 00 0 0 0 0 1 0 1 1 1 0 80000000 0 2 80000004 0 1 0
0 0 00 0 0 0 0 e 0 0 0 0 0 80000000 0 0 80000004 0 0 1
0 0 00 0 0 0 0 1 0 0 2 3 0 80000000 0 5 80000004 0 0 0

/* exu_cluster.f */
+incdir+.
exu_pkg.sv
exu_if.sv
exu_dispatch.sv
exu_lane.sv
exu_collect.sv
exu_cluster.sv
exu_checker.sv
exu_cluster_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = exu_cluster_tb
FILELIST = exu_cluster.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
